// File: hw/vrc6_pkg.sv
// ********************
// VRC6 mapper shared definitions
// cpu write bus, bank and channel register structs
// scanline lengths, saw step count and register pages
// ********************
package vrc6_pkg;

    // scanline length in cpu cycles
    localparam int prescale_long  = 113;
    localparam int prescale_short = 112;

    localparam int saw_steps   = 7;   // accumulator steps per saw period
    localparam int sound_width = 6;   // summed channel level

    // register pages, decoded on address bits 15:12
    localparam logic [15:0] reg_prg16  = 16'h8000;
    localparam logic [15:0] reg_pulse1 = 16'h9000;
    localparam logic [15:0] reg_pulse2 = 16'hA000;
    localparam logic [15:0] reg_saw    = 16'hB000;  // mirror select at Bxx3
    localparam logic [15:0] reg_prg8   = 16'hC000;
    localparam logic [15:0] reg_chr_lo = 16'hD000;
    localparam logic [15:0] reg_chr_hi = 16'hE000;
    localparam logic [15:0] reg_irq    = 16'hF000;

    typedef logic [5:0] prg_bank_t;  // address bits 18:13
    typedef logic [7:0] chr_bank_t;  // 1k bank, address bits 17:10

    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_bus_t;

    typedef struct packed {
        logic [4:0]      prg16;   // A13 is appended below it
        prg_bank_t       prg8;
        chr_bank_t [7:0] chr;
        logic [1:0]      mirror;
    } bank_regs_t;

    typedef struct packed {
        logic [7:0] latch;
        logic       mode;     // 1 counts every cpu cycle
        logic       ack_en;   // enable taken on acknowledge
        logic       ctrl_wr;
        logic       enable;   // qualifies ctrl_wr
        logic       ack_wr;
    } irq_cmd_t;

    typedef struct packed {
        logic        mode;    // constant volume when set
        logic [2:0]  duty;
        logic [3:0]  volume;
        logic [11:0] period;
        logic        enable;
    } pulse_regs_t;

    typedef struct packed {
        logic [5:0]  rate;
        logic [11:0] period;
        logic        enable;
    } saw_regs_t;

endpackage

// File: hw/vrc6_regs.sv
// ********************
// VRC6 register file
// write decode, bank, channel and IRQ registers
// ********************
module vrc6_regs #(
    parameter bit swap_a01 = 1'b0
) (
    input  logic                  clk20,
    input  logic                  reset,
    input  logic                  ce,
    input  vrc6_pkg::cpu_bus_t    cpu,
    output vrc6_pkg::bank_regs_t  banks,
    output vrc6_pkg::irq_cmd_t    irq_cmd,
    output vrc6_pkg::pulse_regs_t pulse1,
    output vrc6_pkg::pulse_regs_t pulse2,
    output vrc6_pkg::saw_regs_t   saw
);

    logic [15:0] addr;       // after the board's A0/A1 swap
    logic        wr_en;
    logic        irq_sel;
    logic [7:0]  irq_latch;
    logic        irq_mode;

    // both pulse channels share one register layout
    function automatic vrc6_pkg::pulse_regs_t pulse_write(
        input vrc6_pkg::pulse_regs_t cur,
        input logic [1:0]            sel,
        input logic [7:0]            data
    );
        vrc6_pkg::pulse_regs_t nxt;
        nxt = cur;
        case (sel)
            2'd0: {nxt.mode, nxt.duty, nxt.volume} = data;
            2'd1: nxt.period[7:0] = data;
            2'd2: {nxt.enable, nxt.period[11:8]} = {data[7], data[3:0]};
            default: nxt = cur;
        endcase
        return nxt;
    endfunction

    assign addr    = swap_a01 ? {cpu.addr[15:2], cpu.addr[0], cpu.addr[1]} : cpu.addr;
    assign wr_en   = ce & cpu.wr;
    assign irq_sel = wr_en && ({addr[15:12], 12'h000} == vrc6_pkg::reg_irq);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            banks     <= '0;
            pulse1    <= '0;
            pulse2    <= '0;
            saw       <= '0;
            irq_latch <= '0;
            irq_mode  <= 1'b0;
        end else if (wr_en) begin
            case ({addr[15:12], 12'h000})
                vrc6_pkg::reg_prg16:  banks.prg16 <= cpu.data[4:0];
                vrc6_pkg::reg_pulse1: pulse1 <= pulse_write(pulse1, addr[1:0], cpu.data);
                vrc6_pkg::reg_pulse2: pulse2 <= pulse_write(pulse2, addr[1:0], cpu.data);
                vrc6_pkg::reg_saw: begin
                    case (addr[1:0])
                        2'd0: saw.rate <= cpu.data[5:0];
                        2'd1: saw.period[7:0] <= cpu.data;
                        2'd2: {saw.enable, saw.period[11:8]} <= {cpu.data[7], cpu.data[3:0]};
                        default: banks.mirror <= cpu.data[3:2];
                    endcase
                end
                vrc6_pkg::reg_prg8:   banks.prg8 <= cpu.data[5:0];
                vrc6_pkg::reg_chr_lo: banks.chr[{1'b0, addr[1:0]}] <= cpu.data;
                vrc6_pkg::reg_chr_hi: banks.chr[{1'b1, addr[1:0]}] <= cpu.data;
                vrc6_pkg::reg_irq: begin
                    if (addr[1:0] == 2'd0) begin
                        irq_latch <= cpu.data;
                    end else if (addr[1:0] == 2'd1) begin
                        irq_mode <= cpu.data[2];
                    end
                end
                default: ;
            endcase
        end
    end

    // strobes act on the accepting edge, data bits ride along with them
    assign irq_cmd = '{
        latch:   irq_latch,
        mode:    irq_mode,
        ack_en:  cpu.data[0],
        ctrl_wr: irq_sel && (addr[1:0] == 2'd1),
        enable:  cpu.data[1],
        ack_wr:  irq_sel && (addr[1:0] == 2'd2)
    };

endmodule

// File: hw/vrc6_banks.sv
// ********************
// VRC6 bank translation
// PRG windows, CHR 1k banks, nametable mirroring
// ********************
module vrc6_banks (
    input  vrc6_pkg::bank_regs_t banks,
    input  logic [15:0]          prg_addr,
    input  logic [13:0]          chr_addr,
    output vrc6_pkg::prg_bank_t  prg_bank,
    output vrc6_pkg::chr_bank_t  chr_bank_out,
    output logic                 ciram_ce
);

    vrc6_pkg::chr_bank_t chr_sel;
    logic                nt_a10;   // ciram page for nametables

    always_comb begin
        casez (prg_addr[15:13])
            3'b0??:  prg_bank = '0;                              // wram window
            3'b10?:  prg_bank = {banks.prg16, prg_addr[13]};     // 8000-BFFF
            3'b110:  prg_bank = banks.prg8;                      // C000-DFFF
            default: prg_bank = '1;                              // fixed last bank
        endcase
    end

    assign chr_sel = banks.chr[chr_addr[12:10]];

    always_comb begin
        case (banks.mirror)
            2'd0:    nt_a10 = chr_addr[10];  // vertical
            2'd1:    nt_a10 = chr_addr[11];  // horizontal
            2'd2:    nt_a10 = 1'b0;
            default: nt_a10 = 1'b1;
        endcase
    end

    // A13 high means a nametable fetch
    assign ciram_ce     = chr_addr[13];
    assign chr_bank_out = {chr_sel[7:1], ciram_ce ? nt_a10 : chr_sel[0]};

endmodule

// File: hw/vrc6_irq.sv
// ********************
// VRC6 IRQ counter
// prescaler, 8-bit counter, reload and acknowledge
// ********************
module vrc6_irq (
    input  logic               clk20,
    input  logic               reset,
    input  logic               ce,
    input  vrc6_pkg::irq_cmd_t irq_cmd,
    output logic               irq
);

    logic       enable;
    logic       ack_en;
    logic [6:0] prescaler;
    logic [1:0] line;        // position in the 3 scanline pattern
    logic [7:0] counter;
    logic       pending;
    logic       count_tick;

    // cycle mode counts every tick
    assign count_tick = irq_cmd.mode | (prescaler == '0);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable    <= 1'b0;
            ack_en    <= 1'b0;
            prescaler <= '0;
            line      <= '0;
            counter   <= '0;
            pending   <= 1'b0;
        end else if (irq_cmd.ctrl_wr) begin
            enable  <= irq_cmd.enable;
            ack_en  <= irq_cmd.ack_en;
            pending <= 1'b0;
            if (irq_cmd.enable) begin
                prescaler <= 7'(vrc6_pkg::prescale_long);
                line      <= 2'd0;
                counter   <= irq_cmd.latch;
            end
        end else if (irq_cmd.ack_wr) begin
            enable  <= ack_en;
            pending <= 1'b0;
        end else if (ce && enable) begin
            if (prescaler != '0) begin
                prescaler <= prescaler - 7'd1;
            end else begin
                // two long lines then one short
                prescaler <= line[1] ? 7'(vrc6_pkg::prescale_short)
                                     : 7'(vrc6_pkg::prescale_long);
                line      <= line[1] ? 2'd0 : line + 2'd1;
            end
            if (count_tick) begin
                if (counter == 8'hFF) begin
                    counter <= irq_cmd.latch;
                    pending <= 1'b1;
                end else begin
                    counter <= counter + 8'd1;
                end
            end
        end
    end

    assign irq = pending;

endmodule

// File: hw/vrc6_pulse.sv
// ********************
// VRC6 pulse channel
// ********************
module vrc6_pulse (
    input  logic                  clk20,
    input  logic                  reset,
    input  logic                  ce,
    input  vrc6_pkg::pulse_regs_t regs,
    output logic [3:0]            level
);

    logic [11:0] divider;
    logic [3:0]  step;       // 16 steps per period
    logic        high;

    // steps 0 up to duty are the high part
    assign high = regs.mode | (step <= {1'b0, regs.duty});

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            divider <= '0;
            step    <= '0;
            level   <= '0;
        end else if (ce) begin
            if (regs.enable) begin
                if (divider != '0) begin
                    divider <= divider - 12'd1;
                end else begin
                    divider <= regs.period;
                    step    <= step + 4'd1;
                end
            end
            level <= (regs.enable && high) ? regs.volume : 4'd0;  // volume gate
        end
    end

endmodule

// File: hw/vrc6_saw.sv
// ********************
// VRC6 sawtooth channel
// divider, 7-step counter, rate accumulator
// ********************
module vrc6_saw (
    input  logic                clk20,
    input  logic                reset,
    input  logic                ce,
    input  vrc6_pkg::saw_regs_t regs,
    output logic [4:0]          level
);

    logic [12:0] divider;
    logic [2:0]  step;
    logic [7:0]  acc;
    logic        last_step;

    assign last_step = (step == 3'(vrc6_pkg::saw_steps - 1));

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            divider <= '0;
            step    <= '0;
            acc     <= '0;
            level   <= '0;
        end else if (ce) begin
            if (regs.enable) begin
                if (divider != '0) begin
                    divider <= divider - 13'd1;
                end else begin
                    // runs at half the pulse clock
                    divider <= {regs.period, 1'b1};
                    if (last_step) begin
                        step <= '0;
                        acc  <= '0;
                    end else begin
                        step <= step + 3'd1;
                        acc  <= acc + {2'b00, regs.rate};
                    end
                end
            end
            level <= regs.enable ? acc[7:3] : 5'd0;
        end
    end

endmodule

// File: hw/vrc6_mapper.sv
// ********************
// VRC6 mapper top level
// register decode, banking, IRQ and expansion sound mix
// ********************
module vrc6_mapper #(
    parameter bit swap_a01 = 1'b0   // board variant with A0/A1 crossed
) (
    input  logic                             clk20,
    input  logic                             reset,
    input  logic                             ce,
    input  vrc6_pkg::cpu_bus_t               cpu,
    input  logic [13:0]                      chr_addr,
    output vrc6_pkg::prg_bank_t              prg_bank,
    output vrc6_pkg::chr_bank_t              chr_bank_out,
    output logic                             ciram_ce,
    output logic                             irq,
    output logic [vrc6_pkg::sound_width-1:0] snd_level
);

    localparam int level_width = vrc6_pkg::sound_width;

    vrc6_pkg::bank_regs_t  banks;
    vrc6_pkg::irq_cmd_t    irq_cmd;
    vrc6_pkg::pulse_regs_t pulse1_regs;
    vrc6_pkg::pulse_regs_t pulse2_regs;
    vrc6_pkg::saw_regs_t   saw_regs;
    logic [3:0]            pulse1_level;
    logic [3:0]            pulse2_level;
    logic [4:0]            saw_level;

    vrc6_regs #(
        .swap_a01 (swap_a01)
    ) regs_i (
        .clk20   (clk20),
        .reset   (reset),
        .ce      (ce),
        .cpu     (cpu),
        .banks   (banks),
        .irq_cmd (irq_cmd),
        .pulse1  (pulse1_regs),
        .pulse2  (pulse2_regs),
        .saw     (saw_regs)
    );

    // translation uses the unswapped cpu address
    vrc6_banks banks_i (
        .banks        (banks),
        .prg_addr     (cpu.addr),
        .chr_addr     (chr_addr),
        .prg_bank     (prg_bank),
        .chr_bank_out (chr_bank_out),
        .ciram_ce     (ciram_ce)
    );

    vrc6_irq irq_i (.clk20(clk20), .reset(reset), .ce(ce), .irq_cmd(irq_cmd), .irq(irq));

    vrc6_pulse pulse1_i (.clk20(clk20), .reset(reset), .ce(ce), .regs(pulse1_regs),
                         .level(pulse1_level));
    vrc6_pulse pulse2_i (.clk20(clk20), .reset(reset), .ce(ce), .regs(pulse2_regs),
                         .level(pulse2_level));

    vrc6_saw saw_i (.clk20(clk20), .reset(reset), .ce(ce), .regs(saw_regs), .level(saw_level));

    // at most 15 + 15 + 31
    assign snd_level = level_width'(pulse1_level) + level_width'(pulse2_level)
                     + level_width'(saw_level);

endmodule

// File: tests/vrc6_tb.sv
// ********************
// VRC6 mapper testbench
// random register writes checked against a shadow model
// ********************
module vrc6_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                             clk20;
    logic                             reset;
    logic                             ce;
    vrc6_pkg::cpu_bus_t               cpu;
    logic [13:0]                      chr_addr;
    vrc6_pkg::prg_bank_t              prg_bank;
    vrc6_pkg::chr_bank_t              chr_bank_out;
    logic                             ciram_ce;
    logic                             irq;
    logic [vrc6_pkg::sound_width-1:0] snd_level;

    integer seed;
    int     errors;
    int     checks;
    int     phase;      // ce on every fourth clock

    // shadow of the register file
    logic [4:0] m_prg16;
    logic [5:0] m_prg8;
    logic [7:0] m_chr [8];
    logic [1:0] m_mirror;
    logic [7:0] m_latch;
    logic       m_p_mode [2];
    logic [3:0] m_p_vol [2];
    logic       m_p_en [2];
    logic [5:0] m_saw_rate;
    logic       m_saw_en;

    vrc6_mapper #(.swap_a01(1'b0)) vrc6_mapper_i (
        .clk20(clk20), .reset(reset), .ce(ce), .cpu(cpu), .chr_addr(chr_addr),
        .prg_bank(prg_bank), .chr_bank_out(chr_bank_out), .ciram_ce(ciram_ce),
        .irq(irq), .snd_level(snd_level)
    );

    always #20 clk20 = ~clk20;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // one clock, inputs change 2 ns after the edge
    task automatic step();
        @(posedge clk20);
        #2;
        phase = (phase + 1) % 4;
        ce = (phase == 3);
    endtask

    task automatic wait_ce_high();
        int guard;
        guard = 0;
        while (!ce && guard < 8) begin
            step();
            guard++;
        end
        if (!ce) begin
            errors++;
            $display("timeout: clock enable never came high");
        end
    endtask

    task automatic ce_tick();   // lets exactly one ce edge pass
        wait_ce_high();
        step();
    endtask

    function automatic void shadow_write(input logic [15:0] a, input logic [7:0] d);
        int ch;
        ch = (a[15:12] == 4'hA) ? 1 : 0;
        case (a[15:12])
            4'h8: m_prg16 = d[4:0];
            4'h9, 4'hA: begin
                if (a[1:0] == 2'd0) begin
                    m_p_mode[ch] = d[7];
                    m_p_vol[ch]  = d[3:0];
                end else if (a[1:0] == 2'd2) begin
                    m_p_en[ch] = d[7];
                end
            end
            4'hB: begin
                if (a[1:0] == 2'd0) m_saw_rate = d[5:0];
                else if (a[1:0] == 2'd2) m_saw_en = d[7];
                else if (a[1:0] == 2'd3) m_mirror = d[3:2];
            end
            4'hC: m_prg8 = d[5:0];
            4'hD: m_chr[{1'b0, a[1:0]}] = d;
            4'hE: m_chr[{1'b1, a[1:0]}] = d;
            4'hF: if (a[1:0] == 2'd0) m_latch = d;
            default: ;
        endcase
    endfunction

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        wait_ce_high();
        cpu = '{wr: 1'b1, addr: a, data: d};
        step();     // accepting edge
        cpu.wr = 1'b0;
        shadow_write(a, d);
    endtask

    function automatic logic [5:0] expected_prg(input logic [15:0] a);
        if (a < 16'h8000) return 6'd0;
        if (a < 16'hC000) return {m_prg16, a[13]};
        if (a < 16'hE000) return m_prg8;
        return 6'h3F;   // last bank is fixed
    endfunction

    function automatic logic [7:0] expected_chr(input logic [13:0] a);
        logic [7:0] b;
        b = m_chr[a[12:10]];
        if (a[13]) begin
            if (m_mirror == 2'd0) b[0] = a[10];
            else if (m_mirror == 2'd1) b[0] = a[11];
            else b[0] = m_mirror[0];    // one-screen page
        end
        return b;
    endfunction

    function automatic logic [5:0] pulse_sum();   // both channels in constant mode
        logic [5:0] s;
        s = 6'd0;
        for (int i = 0; i < 2; i++) begin
            if (m_p_en[i] && m_p_mode[i]) s = s + {2'b00, m_p_vol[i]};
        end
        return s;
    endfunction

    task automatic expect_level(input logic [5:0] want);
        int guard;
        guard = 0;
        while (snd_level !== want && guard < 8) begin
            ce_tick();
            guard++;
        end
        checks++;
        if (snd_level !== want) begin
            errors++;
            $display("ERR snd_level expected %h got %h", want, snd_level);
        end
    endtask

    initial begin
        int          ticks;
        int          exp_ticks;
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  six_rate;
        logic [4:0]  saw_max;
        logic        saw_zero;

        clk20 = 1'b0;
        reset = 1'b1;
        ce = 1'b0;
        cpu = '0;
        chr_addr = '0;
        seed = 44;
        errors = 0;
        checks = 0;
        phase = 0;
        {m_prg16, m_prg8, m_mirror, m_latch, m_saw_rate, m_saw_en} = '0;
        m_chr = '{default: '0};
        m_p_mode = '{default: '0};
        m_p_vol = '{default: '0};
        m_p_en = '{default: '0};

        repeat (10) step();
        reset = 1'b0;
        step();
        checks++;
        if (irq !== 1'b0 || snd_level !== '0) begin
            errors++;
            $display("ERR irq %h snd_level %h after reset, expected 0 0", irq, snd_level);
        end

        // PRG windows
        for (int round = 0; round < 4; round++) begin
            r = next_rand();
            cpu_write(16'h8000, r[7:0]);
            cpu_write(16'hC000, r[15:8]);
            for (int n = 0; n < 16; n++) begin
                r = next_rand();
                a = 16'(32'h6000 + r % 32'hA000);
                cpu.addr = a;
                step();
                checks++;
                if (prg_bank !== expected_prg(a)) begin
                    errors++;
                    $display("ERR prg_bank addr %h expected %h got %h",
                             a, expected_prg(a), prg_bank);
                end
            end
        end

        // CHR banks and nametable mirroring
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < 8; i++) begin
                r = next_rand();
                cpu_write((i < 4 ? 16'hD000 : 16'hE000) | 16'(i % 4), r[7:0]);
            end
            r = next_rand();
            cpu_write(16'hB003, r[7:0]);
            for (int n = 0; n < 16; n++) begin
                r = next_rand();
                chr_addr = r[13:0];
                step();
                checks++;
                if (chr_bank_out !== expected_chr(chr_addr) || ciram_ce !== chr_addr[13]) begin
                    errors++;
                    $display("ERR chr_bank_out ciram_ce addr %h expected %h %h got %h %h",
                             chr_addr, expected_chr(chr_addr), chr_addr[13],
                             chr_bank_out, ciram_ce);
                end
            end
        end

        // IRQ counter in cycle mode
        r = next_rand();
        cpu_write(16'hF000, r[7:0]);
        cpu_write(16'hF001, 8'h06);
        exp_ticks = 256 - int'(m_latch);
        ticks = 0;
        while (irq !== 1'b1 && ticks < 300) begin
            ce_tick();
            ticks++;
        end
        if (irq !== 1'b1) begin
            errors++;
            $display("timeout: irq never rose in cycle mode");
        end else begin
            checks++;
            if (ticks != exp_ticks) begin
                errors++;
                $display("ERR irq rise tick expected %h got %h", exp_ticks, ticks);
            end
        end
        cpu_write(16'hF002, 8'h00);     // acknowledge
        checks++;
        if (irq !== 1'b0) begin
            errors++;
            $display("ERR irq after acknowledge expected 0 got %h", irq);
        end

        // pulse channels at constant volume
        for (int ch = 0; ch < 2; ch++) begin
            r = next_rand();
            a = (ch == 0) ? 16'h9000 : 16'hA000;
            cpu_write(a, {1'b1, r[6:4], r[3:0]});
            cpu_write(a | 16'h0001, r[15:8]);
            cpu_write(a | 16'h0002, {4'h8, r[19:16]});
        end
        expect_level(pulse_sum());
        for (int n = 0; n < 4; n++) begin
            ce_tick();
            checks++;
            if (snd_level !== pulse_sum()) begin
                errors++;
                $display("ERR snd_level hold expected %h got %h", pulse_sum(), snd_level);
            end
        end
        cpu_write(16'h9002, 8'h00);
        expect_level(pulse_sum());

        // sawtooth alone, rate from 8 to 42 so the level moves and 6 * rate fits in 8 bits
        cpu_write(16'hA002, 8'h00);
        expect_level(6'd0);
        r = next_rand();
        cpu_write(16'hB000, 8'(16'd8 + r[15:0] % 16'd35));
        cpu_write(16'hB001, {6'd0, r[17:16]});
        cpu_write(16'hB002, 8'h80);
        six_rate = 8'd6 * {2'b00, m_saw_rate};
        saw_max = six_rate[7:3];
        saw_zero = 1'b0;
        for (int n = 0; n < 200; n++) begin
            ce_tick();
            checks++;
            if (snd_level > {1'b0, saw_max}) begin
                errors++;
                $display("ERR snd_level saw bound %h got %h", saw_max, snd_level);
            end
            if (n >= 16 && snd_level == '0) saw_zero = 1'b1;
        end
        if (!saw_zero) begin
            errors++;
            $display("sawtooth level never returned to zero");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vrc6_mapper.f
hw/vrc6_pkg.sv
hw/vrc6_regs.sv
hw/vrc6_banks.sv
hw/vrc6_irq.sv
hw/vrc6_pulse.sv
hw/vrc6_saw.sv
hw/vrc6_mapper.sv
tests/vrc6_tb.sv

// File: run.sh
#!/bin/sh
# build the VRC6 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f vrc6_mapper.f --top-module vrc6_tb -o vrc6_sim &&
./obj_dir/vrc6_sim | tee /dev/stderr | grep -q "^Done: no errors$" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
